// File: design/prbs_pkg.sv
package prbs_pkg;

    //////////////////////////////
    // widths
    //////////////////////////////
    localparam int apb_addr_w = 8;
    localparam int apb_data_w = 32;
    localparam int phase_w    = 32;
    localparam int dac_w      = 16;
    localparam int lfsr_w     = 23;

    typedef logic [apb_addr_w-1:0]   apb_addr_t;
    typedef logic [apb_data_w-1:0]   apb_data_t;
    typedef logic [phase_w-1:0]      phase_t;
    typedef logic signed [dac_w-1:0] dac_code_t;
    typedef logic [dac_w-1:0]        edge_step_t;
    typedef logic [lfsr_w-1:0]       lfsr_t;

    // sequence select, as held in ctrl bits 2:1
    typedef enum logic [1:0] {
        pn7  = 2'd0,
        pn9  = 2'd1,
        pn15 = 2'd2,
        pn23 = 2'd3
    } pn_sel_t;

    //////////////////////////////
    // register map
    //////////////////////////////
    localparam apb_addr_t reg_ctrl = 8'h00;
    localparam apb_addr_t reg_rate = 8'h04;
    localparam apb_addr_t reg_edge = 8'h08;
    localparam apb_addr_t reg_ampl = 8'h0C;
    localparam apb_addr_t reg_offs = 8'h10;
    localparam apb_addr_t reg_stat = 8'h14;

    // dac code limits for saturation
    localparam dac_code_t dac_max = 16'sh7FFF;
    localparam dac_code_t dac_min = 16'sh8000;

    localparam lfsr_t lfsr_seed = '1;

endpackage

// File: design/prbs_apb_regs.sv
`timescale 1ns/1ps

module prbs_apb_regs (
    input  logic                 dac_clk,
    input  logic                 arst_n,
    input  prbs_pkg::apb_addr_t  paddr,
    input  logic                 psel,
    input  logic                 penable,
    input  logic                 pwrite,
    input  prbs_pkg::apb_data_t  pwdata,
    input  logic                 load_protect,
    output prbs_pkg::apb_data_t  prdata,
    output logic                 pready,
    output logic                 pslverr,
    output logic                 enable,
    output prbs_pkg::pn_sel_t    pn_sel,
    output prbs_pkg::phase_t     rate,
    output prbs_pkg::edge_step_t edge_step,
    output prbs_pkg::dac_code_t  ampl,
    output prbs_pkg::dac_code_t  offs,
    output logic                 protect
);
    import prbs_pkg::*;

    logic      access;
    logic      addr_hit;
    logic      bad_access;
    logic      reg_we;
    logic      [1:0] protect_sync;
    apb_data_t rd_word;

    //////////////////////////////
    // address decode and readback
    //////////////////////////////
    assign access = psel & penable;

    always_comb begin
        addr_hit = 1'b1;
        rd_word  = '0;
        case (paddr)
            reg_ctrl: rd_word = {29'd0, pn_sel, enable};
            reg_rate: rd_word = rate;
            reg_edge: rd_word = {16'd0, edge_step};
            reg_ampl: rd_word = {16'd0, ampl};
            reg_offs: rd_word = {16'd0, offs};
            // bit 1 running, bit 0 protect
            reg_stat: rd_word = {30'd0, enable, protect};
            default:  addr_hit = 1'b0;
        endcase
    end

    // status is read only
    assign bad_access = ~addr_hit | (pwrite & (paddr == reg_stat));

    // zero wait states
    assign pready  = access;
    assign pslverr = access & bad_access;
    assign prdata  = rd_word;
    assign reg_we  = access & pwrite & ~bad_access;

    //////////////////////////////
    // configuration registers
    //////////////////////////////
    always_ff @(posedge dac_clk or negedge arst_n) begin
        if (!arst_n) begin
            enable    <= 1'b0;
            pn_sel    <= pn7;
            rate      <= '0;
            edge_step <= '0;
            ampl      <= '0;
            offs      <= '0;
        end else if (reg_we) begin
            case (paddr)
                reg_ctrl: begin
                    enable <= pwdata[0];
                    pn_sel <= pn_sel_t'(pwdata[2:1]);
                end
                reg_rate: rate      <= pwdata;
                reg_edge: edge_step <= pwdata[15:0];
                reg_ampl: ampl      <= pwdata[15:0];
                reg_offs: offs      <= pwdata[15:0];
                default: begin
                end
            endcase
        end
    end

    // load protect comes from the output stage, async to dac_clk
    always_ff @(posedge dac_clk or negedge arst_n) begin
        if (!arst_n) begin
            protect_sync <= 2'b00;
        end else begin
            protect_sync <= {protect_sync[0], load_protect};
        end
    end

    assign protect = protect_sync[1];

endmodule

// File: design/prbs_rate_nco.sv
`timescale 1ns/1ps

module prbs_rate_nco (
    input  logic              dac_clk,
    input  logic              arst_n,
    input  logic              enable,
    input  prbs_pkg::phase_t  rate,
    output logic              tick
);
    import prbs_pkg::*;

    phase_t                    phase_acc;
    logic   [$bits(phase_t):0] phase_sum;

    // carry out of the add is the bit boundary
    assign phase_sum = {1'b0, phase_acc} + {1'b0, rate};

    //////////////////////////////
    // phase accumulator
    //////////////////////////////
    always_ff @(posedge dac_clk or negedge arst_n) begin
        if (!arst_n) begin
            phase_acc <= '0;
            tick      <= 1'b0;
        end else if (!enable) begin
            // idle, restart from zero phase
            phase_acc <= '0;
            tick      <= 1'b0;
        end else begin
            phase_acc <= phase_sum[$bits(phase_t)-1:0];
            tick      <= phase_sum[$bits(phase_t)];
        end
    end

endmodule

// File: design/prbs_lfsr.sv
`timescale 1ns/1ps

module prbs_lfsr (
    input  logic              dac_clk,
    input  logic              arst_n,
    input  logic              enable,
    input  prbs_pkg::pn_sel_t pn_sel,
    input  logic              tick,
    output logic              bit_valid,
    output logic              bit_value
);
    import prbs_pkg::*;

    lfsr_t lfsr_state;
    logic  feedback;

    //////////////////////////////
    // tap select
    //////////////////////////////
    // shorter sequences live in the low bits
    always_comb begin
        feedback = 1'b0;
        case (pn_sel)
            pn7:  feedback = lfsr_state[6]  ^ lfsr_state[5];
            pn9:  feedback = lfsr_state[8]  ^ lfsr_state[4];
            pn15: feedback = lfsr_state[14] ^ lfsr_state[13];
            pn23: feedback = lfsr_state[22] ^ lfsr_state[17];
        endcase
    end

    //////////////////////////////
    // shift register
    //////////////////////////////
    always_ff @(posedge dac_clk or negedge arst_n) begin
        if (!arst_n) begin
            lfsr_state <= lfsr_seed;
            bit_valid  <= 1'b0;
        end else if (!enable) begin
            // hold the seed so every run starts the same
            lfsr_state <= lfsr_seed;
            bit_valid  <= 1'b0;
        end else begin
            bit_valid <= tick;
            if (tick) begin
                lfsr_state <= {lfsr_state[$bits(lfsr_t)-2:0], feedback};
            end
        end
    end

    // new bit 0, only meaningful with bit_valid
    always_ff @(posedge dac_clk) begin
        if (enable && tick) begin
            bit_value <= feedback;
        end
    end

endmodule

// File: design/prbs_level_shaper.sv
`timescale 1ns/1ps

module prbs_level_shaper (
    input  logic                 dac_clk,
    input  logic                 arst_n,
    input  logic                 bit_valid,
    input  logic                 bit_value,
    input  prbs_pkg::dac_code_t  ampl,
    input  prbs_pkg::dac_code_t  offs,
    input  prbs_pkg::edge_step_t edge_step,
    input  logic                 protect,
    output prbs_pkg::dac_code_t  dac_data
);
    import prbs_pkg::*;

    logic signed [dac_w:0] level_sum;
    dac_code_t             level_sat;
    dac_code_t             target;
    logic signed [dac_w:0] distance;
    logic signed [dac_w:0] step_wide;

    //////////////////////////////
    // target level
    //////////////////////////////
    // one extra bit so the sum cannot wrap
    always_comb begin
        if (bit_value) begin
            level_sum = {offs[dac_w-1], offs} + {ampl[dac_w-1], ampl};
        end else begin
            level_sum = {offs[dac_w-1], offs} - {ampl[dac_w-1], ampl};
        end
        if (level_sum > dac_max) begin
            level_sat = dac_max;
        end else if (level_sum < dac_min) begin
            level_sat = dac_min;
        end else begin
            level_sat = level_sum[dac_w-1:0];
        end
    end

    always_ff @(posedge dac_clk or negedge arst_n) begin
        if (!arst_n) begin
            target <= '0;
        end else if (protect) begin
            // muted output sits at the offset
            target <= offs;
        end else if (bit_valid) begin
            target <= level_sat;
        end
    end

    //////////////////////////////
    // edge slew
    //////////////////////////////
    assign distance  = {target[dac_w-1], target} - {dac_data[dac_w-1], dac_data};
    assign step_wide = {1'b0, edge_step};

    // zero step jumps straight to the target
    always_ff @(posedge dac_clk or negedge arst_n) begin
        if (!arst_n) begin
            dac_data <= '0;
        end else if (edge_step == '0) begin
            dac_data <= target;
        end else if (distance > step_wide) begin
            dac_data <= dac_data + dac_code_t'(edge_step);
        end else if (distance < -step_wide) begin
            dac_data <= dac_data - dac_code_t'(edge_step);
        end else begin
            dac_data <= target;
        end
    end

endmodule

// File: design/prbs_source_top.sv
`timescale 1ns/1ps

module prbs_source_top (
    input  logic                 dac_clk,
    input  logic                 arst_n,
    input  prbs_pkg::apb_addr_t  paddr,
    input  logic                 psel,
    input  logic                 penable,
    input  logic                 pwrite,
    input  prbs_pkg::apb_data_t  pwdata,
    output prbs_pkg::apb_data_t  prdata,
    output logic                 pready,
    output logic                 pslverr,
    input  logic                 load_protect,
    output prbs_pkg::dac_code_t  dac_data
);
    import prbs_pkg::*;

    logic       enable;
    pn_sel_t    pn_sel;
    phase_t     rate;
    edge_step_t edge_step;
    dac_code_t  ampl;
    dac_code_t  offs;
    logic       protect;
    logic       tick;
    logic       bit_valid;
    logic       bit_value;

    //////////////////////////////
    // host registers
    //////////////////////////////
    prbs_apb_regs u_apb_regs (
        .dac_clk      ( dac_clk      ),
        .arst_n       ( arst_n       ),
        .paddr        ( paddr        ),
        .psel         ( psel         ),
        .penable      ( penable      ),
        .pwrite       ( pwrite       ),
        .pwdata       ( pwdata       ),
        .load_protect ( load_protect ),
        .prdata       ( prdata       ),
        .pready       ( pready       ),
        .pslverr      ( pslverr      ),
        .enable       ( enable       ),
        .pn_sel       ( pn_sel       ),
        .rate         ( rate         ),
        .edge_step    ( edge_step    ),
        .ampl         ( ampl         ),
        .offs         ( offs         ),
        .protect      ( protect      )
    );

    //////////////////////////////
    // bit rate, sequence, level
    //////////////////////////////
    prbs_rate_nco u_rate_nco (
        .dac_clk ( dac_clk ),
        .arst_n  ( arst_n  ),
        .enable  ( enable  ),
        .rate    ( rate    ),
        .tick    ( tick    )
    );

    prbs_lfsr u_lfsr (
        .dac_clk   ( dac_clk   ),
        .arst_n    ( arst_n    ),
        .enable    ( enable    ),
        .pn_sel    ( pn_sel    ),
        .tick      ( tick      ),
        .bit_valid ( bit_valid ),
        .bit_value ( bit_value )
    );

    prbs_level_shaper u_level_shaper (
        .dac_clk   ( dac_clk   ),
        .arst_n    ( arst_n    ),
        .bit_valid ( bit_valid ),
        .bit_value ( bit_value ),
        .ampl      ( ampl      ),
        .offs      ( offs      ),
        .edge_step ( edge_step ),
        .protect   ( protect   ),
        .dac_data  ( dac_data  )
    );

endmodule

// File: testbench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter real half_period_ns = 4.0
) (
    output logic clk
);
    initial begin
        clk = 1'b0;
        forever #(half_period_ns) clk = ~clk;
    end
endmodule

// File: testbench/prbs_source_checker.sv
`timescale 1ns/1ps

module prbs_source_checker (
    input logic                dac_clk,
    input logic                arst_n,
    input logic                psel,
    input logic                penable,
    input logic                pready,
    input logic                pslverr,
    input prbs_pkg::dac_code_t dac_data
);
    int pready_fails = 0;
    int pslverr_fails = 0;
    int reset_fails = 0;

    //////////////////////////////
    // apb access phase
    //////////////////////////////
    pready_in_access : assert property (@(posedge dac_clk) disable iff (!arst_n)
        (psel && penable) |-> pready)
        else begin
            pready_fails++;
            $error("pready low during an access phase");
        end

    // error response only inside an access
    pslverr_in_access : assert property (@(posedge dac_clk) disable iff (!arst_n)
        !(psel && penable) |-> !pslverr)
        else begin
            pslverr_fails++;
            $error("pslverr high outside an access phase");
        end

    dac_zero_in_reset : assert property (@(posedge dac_clk) !arst_n |-> (dac_data == '0))
        else begin
            reset_fails++;
            $error("dac_data not zero during reset");
        end
endmodule

bind prbs_source_top prbs_source_checker u_checker (.*);

// File: testbench/tb_prbs_source.sv
`timescale 1ns/1ps

module tb_prbs_source;
    import prbs_pkg::*;

    localparam int apb_limit = 16;

    logic      dac_clk;
    logic      arst_n;
    apb_addr_t paddr;
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_data_t pwdata;
    apb_data_t prdata;
    logic      pready;
    logic      pslverr;
    logic      load_protect;
    dac_code_t dac_data;

    // feedback taps indexed by pn_sel
    int taps [4][2] = '{'{7, 6}, '{9, 5}, '{15, 14}, '{23, 18}};

    tb_clock u_clock (.clk(dac_clk));

    prbs_source_top i_prbs_source_top (
        .dac_clk      ( dac_clk      ),
        .arst_n       ( arst_n       ),
        .paddr        ( paddr        ),
        .psel         ( psel         ),
        .penable      ( penable      ),
        .pwrite       ( pwrite       ),
        .pwdata       ( pwdata       ),
        .prdata       ( prdata       ),
        .pready       ( pready       ),
        .pslverr      ( pslverr      ),
        .load_protect ( load_protect ),
        .dac_data     ( dac_data     )
    );

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_data(input string name, input apb_data_t got, input apb_data_t exp);
        if (got !== exp) begin
            stop_run($sformatf("MISMATCH %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_code(input string name, input dac_code_t got, input dac_code_t exp);
        if (got !== exp) begin
            stop_run($sformatf("MISMATCH %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_run($sformatf("MISMATCH %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    //////////////////////////////
    // apb host
    //////////////////////////////
    task automatic apb_access(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
                              output apb_data_t rdata, output logic err);
        int waited;
        waited = 0;
        @(posedge dac_clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge dac_clk);
        penable <= 1'b1;
        // look at the response in the low half of the clock
        @(negedge dac_clk);
        while (!pready) begin
            waited++;
            if (waited > apb_limit) begin
                stop_run("APB access never saw pready");
            end
            @(negedge dac_clk);
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge dac_clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_write(input apb_addr_t addr, input apb_data_t data);
        apb_data_t unused;
        logic      err;
        apb_access(1'b1, addr, data, unused, err);
        check_flag("pslverr", err, 1'b0);
    endtask

    task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic err);
        apb_access(1'b0, addr, '0, data, err);
    endtask

    task automatic read_expect(input apb_addr_t addr, input apb_data_t exp);
        apb_data_t data;
        logic      err;
        apb_read(addr, data, err);
        check_flag("pslverr", err, 1'b0);
        check_data("prdata", data, exp);
    endtask

    task automatic configure(input pn_sel_t sel, input phase_t rate, input edge_step_t step,
                             input dac_code_t ampl, input dac_code_t offs);
        // disabling first puts the sequence back at its seed
        apb_write(reg_ctrl, 32'h0);
        apb_write(reg_rate, rate);
        apb_write(reg_edge, {16'd0, step});
        apb_write(reg_ampl, {16'd0, ampl});
        apb_write(reg_offs, {16'd0, offs});
        apb_write(reg_ctrl, {29'd0, sel, 1'b1});
    endtask

    //////////////////////////////
    // reference model
    //////////////////////////////
    function automatic lfsr_t lfsr_step(input lfsr_t state, input pn_sel_t sel);
        logic fb;
        fb = state[taps[int'(sel)][0] - 1] ^ state[taps[int'(sel)][1] - 1];
        return {state[$bits(lfsr_t)-2:0], fb};
    endfunction

    function automatic dac_code_t expected_level(input logic b, input dac_code_t offs,
                                                 input dac_code_t ampl);
        int sum;
        sum = b ? int'(offs) + int'(ampl) : int'(offs) - int'(ampl);
        if (sum > 32767) begin
            sum = 32767;
        end
        if (sum < -32768) begin
            sum = -32768;
        end
        return dac_code_t'(sum);
    endfunction

    // max_step of zero skips the slew check
    task automatic wait_level(input dac_code_t target, input int max_step, input int limit,
                              inout dac_code_t prev);
        int waited;
        int diff;
        waited = 0;
        while (dac_data !== target) begin
            waited++;
            if (waited > limit) begin
                stop_run("dac_data did not reach its level in time");
            end
            @(negedge dac_clk);
            diff = int'(dac_data) - int'(prev);
            if (max_step > 0 && (diff > max_step || diff < -max_step)) begin
                stop_run($sformatf("MISMATCH dac_data step 0x%h exceeds 0x%h", diff, max_step));
            end
            prev = dac_data;
        end
    endtask

    //////////////////////////////
    // directed tests
    //////////////////////////////
    task automatic registers_readback();
        apb_data_t rate_val;
        apb_data_t edge_val;
        apb_data_t ampl_val;
        apb_data_t offs_val;
        apb_data_t data;
        logic      err;
        rate_val = $urandom();
        edge_val = $urandom_range(32'hffff, 0);
        ampl_val = $urandom_range(32'hffff, 0);
        offs_val = $urandom_range(32'hffff, 0);
        apb_write(reg_rate, rate_val);
        apb_write(reg_edge, edge_val);
        apb_write(reg_ampl, ampl_val);
        apb_write(reg_offs, offs_val);
        read_expect(reg_rate, rate_val);
        read_expect(reg_edge, edge_val);
        read_expect(reg_ampl, ampl_val);
        read_expect(reg_offs, offs_val);
        apb_write(reg_ctrl, 32'h1);
        read_expect(reg_stat, 32'h2);
        apb_read(8'h20, data, err);
        check_flag("pslverr", err, 1'b1);
        check_data("prdata", data, 32'h0);
        apb_access(1'b1, reg_stat, 32'h0, data, err);
        check_flag("pslverr", err, 1'b1);
        read_expect(reg_stat, 32'h2);
        apb_write(reg_ctrl, 32'h0);
    endtask

    task automatic pn_sequence(input pn_sel_t sel, input dac_code_t ampl, input dac_code_t offs,
                               input int nbits);
        lfsr_t     state;
        dac_code_t level;
        state = lfsr_seed;
        configure(sel, 32'h8000_0000, 16'h0000, ampl, offs);
        // enable at edge e, carry at e+2, level out at e+5
        repeat (5) @(posedge dac_clk);
        for (int k = 0; k < nbits; k++) begin
            state = lfsr_step(state, sel);
            level = expected_level(state[0], offs, ampl);
            @(negedge dac_clk);
            check_code("dac_data", dac_data, level);
            @(negedge dac_clk);
            check_code("dac_data", dac_data, level);
        end
    endtask

    task automatic edge_slew();
        lfsr_t     state;
        dac_code_t prev;
        state = lfsr_seed;
        configure(pn7, 32'h0100_0000, 16'h0100, 16'sh0800, 16'sh0000);
        @(negedge dac_clk);
        prev = dac_data;
        // pn7 from the seed gives six zeros, then a one
        for (int k = 0; k < 10; k++) begin
            state = lfsr_step(state, pn7);
            wait_level(expected_level(state[0], 16'sh0000, 16'sh0800), 256, 3000, prev);
        end
    endtask

    task automatic protect_mute();
        dac_code_t ampl;
        dac_code_t offs;
        dac_code_t prev;
        dac_code_t got;
        int        waited;
        ampl = dac_code_t'($urandom_range(32'h1fff, 32'h0100));
        offs = dac_code_t'($urandom_range(32'h3fff, 0) - 32'h2000);
        configure(pn9, 32'h8000_0000, 16'h0000, ampl, offs);
        @(posedge dac_clk);
        load_protect <= 1'b1;
        @(negedge dac_clk);
        prev = dac_data;
        wait_level(offs, 0, 100, prev);
        read_expect(reg_stat, 32'h3);
        @(negedge dac_clk);
        check_code("dac_data", dac_data, offs);
        @(posedge dac_clk);
        load_protect <= 1'b0;
        waited = 0;
        while (dac_data === offs) begin
            waited++;
            if (waited > 100) begin
                stop_run("dac_data stayed at the offset after protect release");
            end
            @(negedge dac_clk);
        end
        got = dac_data;
        // the sequence kept running under protect so either level may show
        if (got !== expected_level(1'b1, offs, ampl)) begin
            check_code("dac_data", got, expected_level(1'b0, offs, ampl));
        end
        read_expect(reg_stat, 32'h2);
    endtask

    initial begin
        dac_code_t ampl;
        dac_code_t offs;
        int        assert_fails;
        void'($urandom(32'hfabf_1ee3));
        arst_n       = 1'b0;
        paddr        = '0;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        pwdata       = '0;
        load_protect = 1'b0;
        repeat (16) @(posedge dac_clk);
        arst_n <= 1'b1;
        registers_readback();
        for (int s = 0; s < 4; s++) begin
            ampl = dac_code_t'($urandom_range(32'h3fff, 32'h0100));
            offs = dac_code_t'($urandom_range(32'h3fff, 0) - 32'h2000);
            pn_sequence(pn_sel_t'(s), ampl, offs, 64);
        end
        // high level clips at full scale
        pn_sequence(pn7, 16'sh3000, 16'sh7000, 16);
        edge_slew();
        protect_mute();
        assert_fails = i_prbs_source_top.u_checker.pready_fails
                     + i_prbs_source_top.u_checker.pslverr_fails
                     + i_prbs_source_top.u_checker.reset_fails;
        if (assert_fails == 0) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            stop_run("bound assertions reported failures");
        end
    end

endmodule

// File: build.f
design/prbs_pkg.sv
design/prbs_apb_regs.sv
design/prbs_rate_nco.sv
design/prbs_lfsr.sv
design/prbs_level_shaper.sv
design/prbs_source_top.sv
testbench/tb_clock.sv
testbench/prbs_source_checker.sv
testbench/tb_prbs_source.sv

// File: run.sh
#!/usr/bin/env bash
# compile with verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_prbs_source -f build.f -o sim_prbs \
    && ./obj_dir/sim_prbs | tee /dev/stderr | grep -F -q "Result: PASSED" \
    && echo "simulation ok" \
    || { echo "simulation not ok"; exit 1; }
